//--- Makefile
# Verilator simulation of the command accelerator
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_accel_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) from $(FILELIST), run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q -x -F "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/accel_defs.svh
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// Stream word width in bits
`define ACCEL_DAT_BITS 64

// Reply sources at the arbiter: parser, checksum, mult
`define ACCEL_NUM_SRC 3

// Returned in bits 15:0 of every status reply
`define ACCEL_VERSION 16'h0103

// Header word layout, each field 8 bits wide
`define ACCEL_FLD_BITS 8
`define ACCEL_OP_LSB 0   // Opcode
`define ACCEL_LEN_LSB 8  // Payload length in words
`define ACCEL_TAG_LSB 16 // Request tag, echoed in the reply

`endif

//--- common/accel_pkg.sv
`default_nettype none

`include "accel_defs.svh"

package accel_pkg;

  // Header opcodes, OP_ERROR only ever appears in replies
  typedef enum logic [`ACCEL_FLD_BITS-1:0] {
    OP_STATUS   = 8'h01,
    OP_CHECKSUM = 8'h02,
    OP_MULT     = 8'h03,
    OP_RESET    = 8'h04,
    OP_ERROR    = 8'hFF
  } accel_op_e;

  // Parser FSM
  typedef enum logic [2:0] {
    PS_IDLE,  // Waiting for a header
    PS_ROUTE, // Payload goes to an engine
    PS_DROP,  // Payload swallowed
    PS_REPLY, // Status or error reply out
    PS_RESET  // One cycle of soft reset
  } parse_state_e;

  // Engine FSM, both engines use it
  typedef enum logic [1:0] {ES_IDLE, ES_RUN, ES_HDR, ES_DATA} eng_state_e;

  // Arbiter grant state
  typedef enum logic {AS_IDLE, AS_LOCKED} arb_state_e;

  // Builds a reply header word
  function automatic logic [`ACCEL_DAT_BITS-1:0] make_hdr(
    accel_op_e                 op,
    logic [`ACCEL_FLD_BITS-1:0] len,
    logic [`ACCEL_FLD_BITS-1:0] tag
  );
    logic [`ACCEL_DAT_BITS-1:0] hdr;
    hdr = '0;
    hdr[`ACCEL_OP_LSB +: `ACCEL_FLD_BITS]  = op;
    hdr[`ACCEL_LEN_LSB +: `ACCEL_FLD_BITS] = len;
    hdr[`ACCEL_TAG_LSB +: `ACCEL_FLD_BITS] = tag;
    return hdr;
  endfunction

endpackage

`default_nettype wire

//--- control/cmd_parser.sv
`timescale 1ns/10ps
`default_nettype none

`include "accel_defs.svh"

module cmd_parser
  import accel_pkg::*;
(
  input  wire logic                       i_clk_100,
  input  wire logic                       i_rst_n,
  input  wire logic [`ACCEL_DAT_BITS-1:0] i_rx_dat,
  input  wire logic                       i_rx_val,
  input  wire logic                       i_rx_sop,
  input  wire logic                       i_rx_eop,
  output      logic                       o_rx_rdy,
  // Checksum engine
  output      logic [`ACCEL_DAT_BITS-1:0] o_cs_dat,
  output      logic                       o_cs_val,
  output      logic                       o_cs_eop,
  output      logic [7:0]                 o_cs_tag,
  output      logic [7:0]                 o_cs_len,
  input  wire logic                       i_cs_rdy,
  // Multiplier engine
  output      logic [`ACCEL_DAT_BITS-1:0] o_mu_dat,
  output      logic                       o_mu_val,
  output      logic                       o_mu_eop,
  output      logic [7:0]                 o_mu_tag,
  output      logic [7:0]                 o_mu_len,
  input  wire logic                       i_mu_rdy,
  // Own replies
  output      logic [`ACCEL_DAT_BITS-1:0] o_rep_dat,
  output      logic                       o_rep_val,
  output      logic                       o_rep_sop,
  output      logic                       o_rep_eop,
  input  wire logic                       i_rep_rdy,
  output      logic                       o_soft_rst
);

  parse_state_e state;
  accel_op_e    rx_op, op_r, rep_op;
  logic [7:0]   rx_len, len_r, tag_r;
  logic [31:0]  pkt_cnt;  // Accepted packets since reset
  logic         live;     // Low only until the first edge after reset
  logic         rep_idx;  // 0 header word, 1 status word
  logic         hdr_acc, last_acc, to_mu;

  // Header fields of the word on the input
  assign rx_op  = accel_op_e'(i_rx_dat[`ACCEL_OP_LSB +: `ACCEL_FLD_BITS]);
  assign rx_len = i_rx_dat[`ACCEL_LEN_LSB +: `ACCEL_FLD_BITS];

  assign hdr_acc  = (state == PS_IDLE) && live && i_rx_val && i_rx_sop;
  assign last_acc = o_rx_rdy && i_rx_val && i_rx_eop;
  assign to_mu    = (op_r == OP_MULT);

  always_comb begin
    case (state)
      PS_IDLE:  o_rx_rdy = live;
      PS_ROUTE: o_rx_rdy = to_mu ? i_mu_rdy : i_cs_rdy; // Stall on busy engine
      PS_DROP:  o_rx_rdy = 1'b1;
      default:  o_rx_rdy = 1'b0;
    endcase
  end

  // Payload passes straight through to the addressed engine
  assign o_cs_dat = i_rx_dat;
  assign o_cs_eop = i_rx_eop;
  assign o_cs_tag = tag_r;
  assign o_cs_len = len_r;
  assign o_cs_val = (state == PS_ROUTE) && !to_mu && i_rx_val;
  assign o_mu_dat = i_rx_dat;
  assign o_mu_eop = i_rx_eop;
  assign o_mu_tag = tag_r;
  assign o_mu_len = len_r;
  assign o_mu_val = (state == PS_ROUTE) && to_mu && i_rx_val;

  // Anything reaching REPLY other than a status request is an error
  assign rep_op    = (op_r == OP_STATUS) ? OP_STATUS : OP_ERROR;
  assign o_rep_val = (state == PS_REPLY);
  assign o_rep_sop = !rep_idx;
  assign o_rep_eop = rep_idx || (rep_op == OP_ERROR); // Error reply is header only
  assign o_rep_dat = rep_idx ? {16'b0, pkt_cnt, `ACCEL_VERSION}
                             : make_hdr(rep_op, (rep_op == OP_ERROR) ? 8'd0 : 8'd1, tag_r);

  assign o_soft_rst = (state == PS_RESET);

  always_ff @(posedge i_clk_100 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= PS_IDLE;
      live    <= 1'b0;
      pkt_cnt <= '0;
      rep_idx <= 1'b0;
    end else begin
      live <= 1'b1;
      case (state)
        PS_IDLE: if (hdr_acc) begin
          pkt_cnt <= pkt_cnt + 32'd1;
          rep_idx <= 1'b0;
          if (i_rx_eop)
            state <= (rx_op == OP_RESET) ? PS_RESET : PS_REPLY;
          else if ((rx_op == OP_CHECKSUM || rx_op == OP_MULT) && rx_len != '0)
            state <= PS_ROUTE;
          else
            state <= PS_DROP;  // Payload of a bad or answered packet
        end
        PS_ROUTE: if (last_acc) state <= PS_IDLE;
        PS_DROP:  if (last_acc) state <= (op_r == OP_RESET) ? PS_RESET : PS_REPLY;
        PS_REPLY: if (i_rep_rdy) begin
          rep_idx <= 1'b1;
          if (o_rep_eop) state <= PS_IDLE;
        end
        PS_RESET: begin
          pkt_cnt <= '0;     // Next status then reads 1
          state   <= PS_IDLE;
        end
        default: state <= PS_IDLE;
      endcase
    end
  end

  // Header fields held for the whole packet
  always_ff @(posedge i_clk_100) begin
    if (hdr_acc) begin
      op_r  <= rx_op;
      len_r <= rx_len;
      tag_r <= i_rx_dat[`ACCEL_TAG_LSB +: `ACCEL_FLD_BITS];
    end
  end

endmodule

`default_nettype wire

//--- engines/checksum_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "accel_defs.svh"

module checksum_engine
  import accel_pkg::*;
(
  input  wire logic                       i_clk_100,
  input  wire logic                       i_rst_n,
  input  wire logic                       i_soft_rst,
  input  wire logic [`ACCEL_DAT_BITS-1:0] i_dat,
  input  wire logic                       i_val,
  input  wire logic                       i_eop,
  input  wire logic [7:0]                 i_tag,
  input  wire logic [7:0]                 i_len,
  output      logic                       o_rdy,
  output      logic [`ACCEL_DAT_BITS-1:0] o_dat,
  output      logic                       o_val,
  output      logic                       o_sop,
  output      logic                       o_eop,
  input  wire logic                       i_rdy
);

  eng_state_e                 state;
  logic [`ACCEL_DAT_BITS-1:0] sum;    // Running sum, wraps at 2^64
  logic [7:0]                 tag_r;
  logic [7:0]                 cnt;    // Index of the word now in RUN
  logic                       acc, last;

  assign o_rdy = (state == ES_IDLE) || (state == ES_RUN); // Busy until reply gone
  assign acc   = o_rdy && i_val;
  // Close on eop or when the header length is reached
  assign last  = i_eop || ((state == ES_IDLE) ? (i_len == 8'd1) : (cnt == i_len));

  assign o_val = (state == ES_HDR) || (state == ES_DATA);
  assign o_sop = (state == ES_HDR);
  assign o_eop = (state == ES_DATA);
  assign o_dat = (state == ES_HDR) ? make_hdr(OP_CHECKSUM, 8'd1, tag_r) : sum;

  always_ff @(posedge i_clk_100 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ES_IDLE;
    end else if (i_soft_rst) begin
      state <= ES_IDLE;
    end else begin
      case (state)
        ES_IDLE: if (acc) state <= last ? ES_HDR : ES_RUN;
        ES_RUN:  if (acc && last) state <= ES_HDR;
        ES_HDR:  if (i_rdy) state <= ES_DATA;
        ES_DATA: if (i_rdy) state <= ES_IDLE;
        default: state <= ES_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (acc) begin
      sum <= (state == ES_IDLE) ? i_dat : sum + i_dat; // First word loads
      cnt <= (state == ES_IDLE) ? 8'd2 : cnt + 8'd1;
    end
    if (acc && state == ES_IDLE) tag_r <= i_tag;
  end

endmodule

`default_nettype wire

//--- engines/mult_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "accel_defs.svh"

module mult_engine
  import accel_pkg::*;
(
  input  wire logic                       i_clk_100,
  input  wire logic                       i_rst_n,
  input  wire logic                       i_soft_rst,
  input  wire logic [`ACCEL_DAT_BITS-1:0] i_dat,
  input  wire logic                       i_val,
  input  wire logic                       i_eop,
  input  wire logic [7:0]                 i_tag,
  input  wire logic [7:0]                 i_len,
  output      logic                       o_rdy,
  output      logic [`ACCEL_DAT_BITS-1:0] o_dat,
  output      logic                       o_val,
  output      logic                       o_sop,
  output      logic                       o_eop,
  input  wire logic                       i_rdy
);

  eng_state_e                 state;
  logic [`ACCEL_DAT_BITS-1:0] mcand;   // Low half, shifted left each step
  logic [`ACCEL_DAT_BITS-1:0] prod;
  logic [31:0]                mplier;  // High half, shifted right each step
  logic [4:0]                 step;
  logic                       loaded;  // Operands in, shift-add running
  logic                       last_r;  // Word being multiplied had eop
  logic [7:0]                 tag_r, len_r;

  assign o_rdy = (state == ES_RUN) && !loaded; // One word at a time
  assign o_val = (state == ES_HDR) || (state == ES_DATA);
  assign o_sop = (state == ES_HDR);
  assign o_eop = (state == ES_DATA) && last_r;
  assign o_dat = (state == ES_HDR) ? make_hdr(OP_MULT, len_r, tag_r) : prod;

  always_ff @(posedge i_clk_100 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state  <= ES_IDLE;
      loaded <= 1'b0;
      step   <= '0;
    end else if (i_soft_rst) begin
      state  <= ES_IDLE;
      loaded <= 1'b0;
      step   <= '0;
    end else begin
      case (state)
        ES_IDLE: if (i_val) state <= ES_HDR;  // Header goes out before any product
        ES_HDR:  if (i_rdy) state <= ES_RUN;
        ES_RUN: begin
          if (!loaded) begin
            if (i_val) begin
              loaded <= 1'b1;
              step   <= '0;
            end
          end else begin
            step <= step + 5'd1;
            if (step == 5'd31) begin  // 32 steps done
              loaded <= 1'b0;
              state  <= ES_DATA;
            end
          end
        end
        ES_DATA: if (i_rdy) state <= last_r ? ES_IDLE : ES_RUN;
        default: state <= ES_IDLE;
      endcase
    end
  end

  // Shift-add datapath
  always_ff @(posedge i_clk_100) begin
    if (state == ES_IDLE && i_val) begin
      tag_r <= i_tag;
      len_r <= i_len;  // Reply has one product per payload word
    end
    if (o_rdy && i_val) begin
      mcand  <= {32'b0, i_dat[31:0]};
      mplier <= i_dat[63:32];
      prod   <= '0;
      last_r <= i_eop;
    end else if (state == ES_RUN && loaded) begin
      if (mplier[0]) prod <= prod + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/accel_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "accel_defs.svh"

module accel_top (
  input  wire logic                       i_clk_100,
  input  wire logic                       i_rst_n,
  // Command stream in
  input  wire logic [`ACCEL_DAT_BITS-1:0] i_rx_dat,
  input  wire logic                       i_rx_val,
  input  wire logic                       i_rx_sop,
  input  wire logic                       i_rx_eop,
  output      logic                       o_rx_rdy,
  // Reply stream out
  output      logic [`ACCEL_DAT_BITS-1:0] o_tx_dat,
  output      logic                       o_tx_val,
  output      logic                       o_tx_sop,
  output      logic                       o_tx_eop,
  input  wire logic                       i_tx_rdy
);

  // Parser to engines
  logic [`ACCEL_DAT_BITS-1:0] cs_dat, mu_dat;
  logic                       cs_val, cs_eop, cs_rdy;
  logic                       mu_val, mu_eop, mu_rdy;
  logic [7:0]                 cs_tag, cs_len, mu_tag, mu_len;
  logic                       soft_rst; // Pulses on OP_RESET

  // Reply sources: 0 parser, 1 checksum, 2 mult
  logic [`ACCEL_DAT_BITS-1:0] src_dat [`ACCEL_NUM_SRC];
  logic                       src_val [`ACCEL_NUM_SRC];
  logic                       src_sop [`ACCEL_NUM_SRC];
  logic                       src_eop [`ACCEL_NUM_SRC];
  logic                       src_rdy [`ACCEL_NUM_SRC];

  cmd_parser u_cmd_parser (
    .i_clk_100  (i_clk_100),  .i_rst_n   (i_rst_n),
    .i_rx_dat   (i_rx_dat),   .i_rx_val  (i_rx_val),
    .i_rx_sop   (i_rx_sop),   .i_rx_eop  (i_rx_eop),   .o_rx_rdy (o_rx_rdy),
    .o_cs_dat   (cs_dat),     .o_cs_val  (cs_val),     .o_cs_eop (cs_eop),
    .o_cs_tag   (cs_tag),     .o_cs_len  (cs_len),     .i_cs_rdy (cs_rdy),
    .o_mu_dat   (mu_dat),     .o_mu_val  (mu_val),     .o_mu_eop (mu_eop),
    .o_mu_tag   (mu_tag),     .o_mu_len  (mu_len),     .i_mu_rdy (mu_rdy),
    .o_rep_dat  (src_dat[0]), .o_rep_val (src_val[0]), .o_rep_sop (src_sop[0]),
    .o_rep_eop  (src_eop[0]), .i_rep_rdy (src_rdy[0]),
    .o_soft_rst (soft_rst)
  );

  checksum_engine u_checksum_engine (
    .i_clk_100 (i_clk_100),  .i_rst_n (i_rst_n),     .i_soft_rst (soft_rst),
    .i_dat     (cs_dat),     .i_val   (cs_val),      .i_eop      (cs_eop),
    .i_tag     (cs_tag),     .i_len   (cs_len),      .o_rdy      (cs_rdy),
    .o_dat     (src_dat[1]), .o_val   (src_val[1]),  .o_sop      (src_sop[1]),
    .o_eop     (src_eop[1]), .i_rdy   (src_rdy[1])
  );

  mult_engine u_mult_engine (
    .i_clk_100 (i_clk_100),  .i_rst_n (i_rst_n),     .i_soft_rst (soft_rst),
    .i_dat     (mu_dat),     .i_val   (mu_val),      .i_eop      (mu_eop),
    .i_tag     (mu_tag),     .i_len   (mu_len),      .o_rdy      (mu_rdy),
    .o_dat     (src_dat[2]), .o_val   (src_val[2]),  .o_sop      (src_sop[2]),
    .o_eop     (src_eop[2]), .i_rdy   (src_rdy[2])
  );

  // Merge the three reply streams onto the transmit side
  packet_arb u_packet_arb (
    .i_clk_100 (i_clk_100), .i_rst_n   (i_rst_n),
    .i_src_dat (src_dat),   .i_src_val (src_val),  .i_src_sop (src_sop),
    .i_src_eop (src_eop),   .o_src_rdy (src_rdy),
    .o_tx_dat  (o_tx_dat),  .o_tx_val  (o_tx_val), .o_tx_sop  (o_tx_sop),
    .o_tx_eop  (o_tx_eop),  .i_tx_rdy  (i_tx_rdy)
  );

endmodule

`default_nettype wire

//--- hdl/packet_arb.sv
`timescale 1ns/10ps
`default_nettype none

`include "accel_defs.svh"

module packet_arb
  import accel_pkg::*;
(
  input  wire logic                       i_clk_100,
  input  wire logic                       i_rst_n,
  input  wire logic [`ACCEL_DAT_BITS-1:0] i_src_dat [`ACCEL_NUM_SRC],
  input  wire logic                       i_src_val [`ACCEL_NUM_SRC],
  input  wire logic                       i_src_sop [`ACCEL_NUM_SRC],
  input  wire logic                       i_src_eop [`ACCEL_NUM_SRC],
  output      logic                       o_src_rdy [`ACCEL_NUM_SRC],
  output      logic [`ACCEL_DAT_BITS-1:0] o_tx_dat,
  output      logic                       o_tx_val,
  output      logic                       o_tx_sop,
  output      logic                       o_tx_eop,
  input  wire logic                       i_tx_rdy
);

  localparam int N  = `ACCEL_NUM_SRC;
  localparam int IW = $clog2(N);

  arb_state_e    state;
  logic [IW-1:0] grant;  // Source owning the output
  logic [IW-1:0] ptr;    // Round-robin start point
  logic [IW-1:0] pick;
  logic          found;
  int            idx;

  // First source from ptr onwards with a packet start waiting
  always_comb begin
    found = 1'b0;
    pick  = ptr;
    idx   = 0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(ptr) + k) % N;
      if (!found && i_src_val[idx] && i_src_sop[idx]) begin
        found = 1'b1;
        pick  = IW'(idx);
      end
    end
  end

  // Granted source drives the output, back-pressure goes straight back
  assign o_tx_dat = i_src_dat[grant];
  assign o_tx_val = (state == AS_LOCKED) && i_src_val[grant];
  assign o_tx_sop = i_src_sop[grant];
  assign o_tx_eop = i_src_eop[grant];

  always_comb begin
    for (int s = 0; s < N; s++)
      o_src_rdy[s] = (state == AS_LOCKED) && (grant == IW'(s)) && i_tx_rdy;
  end

  always_ff @(posedge i_clk_100 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= AS_IDLE;
      grant <= '0;
      ptr   <= '0;
    end else begin
      case (state)
        AS_IDLE: if (found) begin
          grant <= pick;
          state <= AS_LOCKED;
        end
        AS_LOCKED: if (o_tx_val && i_tx_rdy && o_tx_eop) begin
          state <= AS_IDLE;  // Packet done, move priority past the winner
          ptr   <= (grant == IW'(N - 1)) ? '0 : grant + 1'b1;
        end
        default: state <= AS_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/accel_pkg.sv
control/cmd_parser.sv
engines/checksum_engine.sv
engines/mult_engine.sv
hdl/packet_arb.sv
hdl/accel_top.sv
tests/tb_accel_top.sv

//--- tests/tb_accel_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "accel_defs.svh"

module tb_accel_top
  import accel_pkg::*;
();

  logic                       i_clk_100, i_rst_n;
  logic [`ACCEL_DAT_BITS-1:0] i_rx_dat, o_tx_dat;
  logic                       i_rx_val, i_rx_sop, i_rx_eop, o_rx_rdy;
  logic                       o_tx_val, o_tx_sop, o_tx_eop, i_tx_rdy;

  // Scoreboard indexed by tag
  logic [63:0] exp_mem  [256][17]; // Header plus up to 16 payload words
  int          exp_cnt  [256];
  bit          exp_pend [256];
  string       exp_name [256];

  logic [63:0] pay [16];           // Payload of the request being built
  integer      seed;
  logic [7:0]  next_tag;
  int          pkt_model;          // Expected packet counter in the parser
  int          sent_replies, got_replies, stim_words, cycles;
  int          mismatch_cnt, fault_cnt;
  bit          rx_took;            // Word on i_rx was taken at the last rising edge
  bit          in_pkt;
  logic [7:0]  cur_tag;
  int          cur_idx;

  accel_top DUT (
    .i_clk_100 (i_clk_100), .i_rst_n  (i_rst_n),
    .i_rx_dat  (i_rx_dat),  .i_rx_val (i_rx_val), .i_rx_sop (i_rx_sop),
    .i_rx_eop  (i_rx_eop),  .o_rx_rdy (o_rx_rdy),
    .o_tx_dat  (o_tx_dat),  .o_tx_val (o_tx_val), .o_tx_sop (o_tx_sop),
    .o_tx_eop  (o_tx_eop),  .i_tx_rdy (i_tx_rdy)
  );

  always #10 i_clk_100 = ~i_clk_100;  // 20 ns period

  // Reply length in words including the header
  function automatic int reply_len(logic [7:0] op, logic [7:0] len);
    if (op == OP_RESET) return 0;  // No reply at all
    if (op == OP_STATUS || (op == OP_CHECKSUM && len != 8'd0)) return 2;
    if (op == OP_MULT && len != 8'd0) return int'(len) + 1;
    return 1;  // Error reply is a lone header
  endfunction

  // Expected word idx of the reply for the payload in pay
  function automatic logic [63:0] ref_reply(logic [7:0] op, logic [7:0] len,
                                            logic [7:0] tag, int cnt, int idx);
    logic [63:0] sum;
    logic [7:0]  rop;
    int          words;
    sum   = '0;
    words = reply_len(op, len);
    rop   = (words == 1) ? OP_ERROR : op;
    if (idx == 0)
      return {40'b0, tag, 8'(words - 1), rop};
    if (op == OP_STATUS)
      return {16'b0, cnt[31:0], `ACCEL_VERSION};
    if (op == OP_CHECKSUM) begin
      for (int i = 0; i < int'(len); i++)
        sum = sum + pay[i];  // Wraps at 2^64
      return sum;
    end
    return {32'b0, pay[idx-1][31:0]} * {32'b0, pay[idx-1][63:32]};
  endfunction

  task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
    assert (act === exp)
    else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic fill_random(int n);
    for (int i = 0; i < n; i++)
      pay[i] = {$random(seed), $random(seed)};
  endtask

  // Runs from a falling edge to the falling edge after the word is taken
  task automatic send_word(logic [63:0] dat, logic sop, logic eop);
    i_rx_dat = dat;
    i_rx_val = 1'b1;
    i_rx_sop = sop;
    i_rx_eop = eop;
    do @(negedge i_clk_100); while (!rx_took);
    stim_words++;
  endtask

  // Books the expected reply before sending the header and n words of pay
  task automatic send_pkt(string name, logic [7:0] op, logic [7:0] len, int n);
    int words;
    words = reply_len(op, len);
    pkt_model++;
    if (words > 0) begin
      for (int i = 0; i < words; i++)
        exp_mem[next_tag][i] = ref_reply(op, len, next_tag, pkt_model, i);
      exp_cnt[next_tag]  = words;
      exp_name[next_tag] = name;
      exp_pend[next_tag] = 1'b1;
      sent_replies++;
    end
    if (op == OP_RESET) pkt_model = 0;  // Counter cleared after the reset packet
    send_word({40'b0, next_tag, len, op}, 1'b1, n == 0);
    for (int i = 0; i < n; i++)
      send_word(pay[i], 1'b0, i == n - 1);
    i_rx_val = 1'b0;
    next_tag = next_tag + 8'd1;
  endtask

  task automatic drain();
    while (got_replies != sent_replies) @(negedge i_clk_100);
  endtask

  always @(posedge i_clk_100) rx_took <= i_rx_val && o_rx_rdy;

  // Random back-pressure holds i_tx_rdy low one cycle in four
  always @(negedge i_clk_100)
    if (i_rst_n) i_tx_rdy = (($random(seed) & 3) != 0);

  // Reply checker matching each reply to its request by tag
  always @(posedge i_clk_100) begin
    if (i_rst_n && o_tx_val && i_tx_rdy) begin
      if (o_tx_sop) begin
        assert (!in_pkt)
        else begin
          $display("Reply with tag %0d started before reply with tag %0d ended",
                   o_tx_dat[`ACCEL_TAG_LSB +: 8], cur_tag);
          fault_cnt++;
        end
        cur_tag = o_tx_dat[`ACCEL_TAG_LSB +: 8];
        cur_idx = 0;
        in_pkt  = exp_pend[cur_tag];
        assert (in_pkt)
        else begin
          $display("Reply with tag %0d arrived with no request pending", cur_tag);
          fault_cnt++;
        end
      end else begin
        assert (in_pkt)
        else begin
          $display("Reply word arrived outside of a packet");
          fault_cnt++;
        end
      end
      if (in_pkt) begin
        if (cur_idx < exp_cnt[cur_tag])
          check_val(exp_name[cur_tag], exp_mem[cur_tag][cur_idx], o_tx_dat);
        check_val({exp_name[cur_tag], " eop"}, 64'(cur_idx == exp_cnt[cur_tag] - 1),
                  64'(o_tx_eop));
        cur_idx++;
        if (o_tx_eop) begin
          exp_pend[cur_tag] = 1'b0;  // Each tag answered once only
          got_replies++;
          in_pkt = 1'b0;
        end
      end
    end
  end

  // Watchdog limit grows with the words sent
  always @(posedge i_clk_100) begin
    cycles++;
    if (cycles > stim_words * 40 + 2000) begin
      $display("Timeout after %0d cycles, %0d of %0d replies received",
               cycles, got_replies, sent_replies);
      $display("Errors: %0d value mismatches, %0d other failures",
               mismatch_cnt, fault_cnt + 1);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    logic [7:0] len;
    seed      = 32'h399f;
    i_clk_100 = 1'b0;
    i_rst_n   = 1'b0;
    i_rx_dat  = '0;
    i_rx_val  = 1'b0;
    i_rx_sop  = 1'b0;
    i_rx_eop  = 1'b0;
    i_tx_rdy  = 1'b0;
    next_tag  = 8'd0;
    repeat (3) begin
      @(negedge i_clk_100);
      check_val("reset_rx_rdy", 64'd0, 64'(o_rx_rdy));  // Nothing moves in reset
      check_val("reset_tx_val", 64'd0, 64'(o_tx_val));
    end
    i_rst_n = 1'b1;
    @(negedge i_clk_100);
    check_val("rx_rdy_after_reset", 64'd1, 64'(o_rx_rdy));  // Open one cycle out of reset

    send_pkt("status", OP_STATUS, 8'd0, 0);  // First packet reads a count of 1
    repeat (12) begin
      len = 8'(1 + {$random(seed)} % 16);
      fill_random(int'(len));
      send_pkt("checksum", OP_CHECKSUM, len, int'(len));
    end

    pay[0] = '1;                     // All ones times all ones
    pay[1] = '0;
    pay[2] = 64'hFFFF_FFFF_0000_0000;
    pay[3] = 64'h0000_0001_FFFF_FFFF;
    send_pkt("mult_edge", OP_MULT, 8'd4, 4);
    repeat (3) begin
      len = 8'(1 + {$random(seed)} % 4);
      fill_random(int'(len));
      send_pkt("mult", OP_MULT, len, int'(len));
    end

    fill_random(2);
    send_pkt("bad_opcode", 8'h7E, 8'd2, 2);     // Payload dropped
    send_pkt("zero_len_cs", OP_CHECKSUM, 8'd0, 0);
    fill_random(1);
    send_pkt("zero_len_mu", OP_MULT, 8'd0, 1);
    fill_random(3);
    send_pkt("after_error", OP_CHECKSUM, 8'd3, 3);

    for (int p = 0; p < 16; p++) begin         // Both engines busy at once
      len = 8'(1 + {$random(seed)} % 6);
      fill_random(int'(len));
      send_pkt("mixed", p[0] ? OP_MULT : OP_CHECKSUM, len, int'(len));
    end
    send_pkt("status_count", OP_STATUS, 8'd0, 0);
    drain();

    send_pkt("reset", OP_RESET, 8'd0, 0);
    send_pkt("status_after_reset", OP_STATUS, 8'd0, 0);
    drain();
    repeat (20) @(negedge i_clk_100);  // Catch any stray reply words

    $display("Errors: %0d value mismatches, %0d other failures", mismatch_cnt, fault_cnt);
    if (mismatch_cnt == 0 && fault_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
